// File: rtl/axis_switch_macros.svh
`ifndef AXIS_SWITCH_MACROS_SVH
`define AXIS_SWITCH_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// stream field widths
////////////////////////////////////////////////////////////////////////////

`define AXIS_DATA_WIDTH 32
// one keep bit per data byte
`define AXIS_KEEP_WIDTH 4
`define AXIS_USER_WIDTH 2
`define AXIS_TID_WIDTH 2

////////////////////////////////////////////////////////////////////////////
// switch sizing and config
////////////////////////////////////////////////////////////////////////////

`define AXIS_NUM_SOURCES 3
`define AXIS_FIFO_DEPTH 16
// threshold after reset
`define AXIS_TH_RESET 6
`define AXIL_ADDR_WIDTH 15

`endif

// File: rtl/axis_beat_pkg.sv
`include "axis_switch_macros.svh"

package axis_beat_pkg;

    // beat as sent by an on-chip agent
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] data;
        logic [`AXIS_KEEP_WIDTH-1:0] keep;
        logic                        last;
        logic [`AXIS_USER_WIDTH-1:0] user;
    } up_beat_t;

    // beat on the serdes side, tagged with its source id
    typedef struct packed {
        logic [`AXIS_TID_WIDTH-1:0] tid;
        up_beat_t                   beat;
    } ds_beat_t;

endpackage

// File: rtl/switch_cfg_pkg.sv
`include "axis_switch_macros.svh"

package switch_cfg_pkg;

    // upstream source ids, also the tid on the serdes link
    typedef enum logic [`AXIS_TID_WIDTH-1:0] {
        SRC_USER_PROJECT   = 2'd0,
        SRC_AXIL_BRIDGE    = 2'd1,
        SRC_LOGIC_ANALYZER = 2'd2
    } source_id_t;

    typedef logic [3:0] threshold_t;

    // counts 0 to full depth
    typedef logic [$clog2(`AXIS_FIFO_DEPTH):0] occupancy_t;

endpackage

// File: rtl/axis_if.sv
`timescale 1ns/1ps

// valid/ready stream, payload type set per instance
interface axis_if #(
    parameter type payload_t = logic
) ();

    logic     tvalid;
    logic     tready;
    payload_t payload;

    modport source (
        output tvalid,
        output payload,
        input  tready
    );

    modport sink (
        input  tvalid,
        input  payload,
        output tready
    );

endinterface

// File: rtl/threshold_regs.sv
`timescale 1ns/1ps
`include "axis_switch_macros.svh"

module threshold_regs (
    input  logic                            axis_clk,
    input  logic                            axi_reset_n,
    input  logic                            cc_as_enable,
    input  logic                            awvalid,
    input  logic [`AXIL_ADDR_WIDTH-1:0]     awaddr,
    input  logic                            wvalid,
    input  logic [`AXIS_DATA_WIDTH-1:0]     wdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]     wstrb,
    output logic                            awready,
    output logic                            wready,
    output switch_cfg_pkg::threshold_t      threshold
);

    logic wr_take;
    logic hit_th;

    // address and data must arrive together
    assign wr_take = cc_as_enable && awvalid && wvalid;
    assign awready = wr_take;
    assign wready  = wr_take;

    // word offset 0, low byte enabled
    assign hit_th = (awaddr[`AXIL_ADDR_WIDTH-1:2] == '0) && wstrb[0];

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            threshold <= switch_cfg_pkg::threshold_t'(`AXIS_TH_RESET);
        end else if (wr_take && hit_th) begin
            threshold <= wdata[$bits(threshold)-1:0];
        end
    end

endmodule

// File: rtl/frame_arbiter.sv
`timescale 1ns/1ps
`include "axis_switch_macros.svh"

module frame_arbiter (
    input  logic   axis_clk,
    input  logic   axi_reset_n,
    axis_if.sink   src [`AXIS_NUM_SOURCES],
    axis_if.source out
);

    localparam int N  = `AXIS_NUM_SOURCES;
    localparam int PW = $clog2(N);

    logic [N-1:0]               req;
    logic [N-1:0]               src_ready;
    axis_beat_pkg::up_beat_t    beat [N];

    logic [N-1:0]               grant_r;
    logic [N-1:0]               grant_pick;
    logic                       frame_active;
    logic [PW-1:0]              base_ptr;
    logic [PW-1:0]              next_base;

    logic                       sel_valid;
    axis_beat_pkg::up_beat_t    sel_beat;
    switch_cfg_pkg::source_id_t sel_id;
    logic                       load;
    logic                       frame_end;

    logic                       out_valid;
    axis_beat_pkg::ds_beat_t    out_beat;

    for (genvar g = 0; g < N; g++) begin : g_src
        assign req[g]        = src[g].tvalid;
        assign beat[g]       = src[g].payload;
        assign src[g].tready = src_ready[g];
    end

    ////////////////////////////////////////////////////////////////////////////
    // round robin pick
    ////////////////////////////////////////////////////////////////////////////

    // scan down so the lowest offset from base_ptr wins
    always_comb begin
        int idx;
        grant_pick = '0;
        next_base  = base_ptr;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(base_ptr) + k) % N;
            if (req[idx]) begin
                grant_pick      = '0;
                grant_pick[idx] = 1'b1;
                next_base       = PW'((idx + 1) % N);
            end
        end
    end

    // mux of the granted source
    always_comb begin
        sel_valid = 1'b0;
        sel_beat  = beat[0];
        sel_id    = switch_cfg_pkg::SRC_USER_PROJECT;
        for (int i = 0; i < N; i++) begin
            if (grant_r[i]) begin
                sel_valid = req[i];
                sel_beat  = beat[i];
                sel_id    = switch_cfg_pkg::source_id_t'(i);
            end
        end
    end

    // output register empty or draining this cycle
    assign src_ready = grant_r & {N{!out_valid || out.tready}};
    assign load      = sel_valid && (!out_valid || out.tready);
    assign frame_end = load && sel_beat.last;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            grant_r      <= '0;
            frame_active <= 1'b0;
            base_ptr     <= '0;
        end else if (!frame_active) begin
            grant_r      <= grant_pick;
            frame_active <= |grant_pick;
            base_ptr     <= next_base;
        end else if (frame_end) begin
            grant_r      <= '0;
            frame_active <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // serdes output stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out.tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load) begin
            out_beat.tid  <= sel_id;
            out_beat.beat <= sel_beat;
        end
    end

    assign out.tvalid  = out_valid;
    assign out.payload = out_beat;

    a_grant_onehot: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0(grant_r));

    // no source switch until its tlast beat is taken
    a_grant_held: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        frame_active && !frame_end |=> grant_r == $past(grant_r));

endmodule

// File: rtl/rx_fifo.sv
`timescale 1ns/1ps
`include "axis_switch_macros.svh"

module rx_fifo (
    input  logic                       axis_clk,
    input  logic                       axi_reset_n,
    input  switch_cfg_pkg::threshold_t threshold,
    axis_if.sink                       wr,
    axis_if.source                     rd
);

    localparam int DEPTH = `AXIS_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    axis_beat_pkg::ds_beat_t    mem [DEPTH];
    logic [AW:0]                wr_ptr;
    logic [AW:0]                rd_ptr;
    switch_cfg_pkg::occupancy_t occupancy;
    logic                       empty;
    logic                       full;
    logic                       wr_en;
    logic                       rd_en;

    // extra msb on each pointer tells full from empty
    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (occupancy == '0);
    assign full      = (occupancy == switch_cfg_pkg::occupancy_t'(DEPTH));

    // serdes ready follows registered occupancy only
    assign wr.tready = (occupancy <= switch_cfg_pkg::occupancy_t'(threshold));
    assign wr_en     = wr.tvalid && wr.tready;

    // show-ahead head
    assign rd.tvalid  = !empty;
    assign rd.payload = mem[rd_ptr[AW-1:0]];
    assign rd_en      = rd.tvalid && rd.tready;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr.payload;
        end
    end

    // the 4-bit threshold must keep a full FIFO closed
    a_no_overflow: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        wr_en |-> !full);

    // read pointer only moves off a non-empty FIFO
    a_no_underflow: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        rd_ptr != $past(rd_ptr) |-> $past(wr_ptr != rd_ptr));

endmodule

// File: rtl/tid_router.sv
`timescale 1ns/1ps

module tid_router (
    input  logic   axis_clk,
    input  logic   axi_reset_n,
    axis_if.sink   head,
    axis_if.source up,
    axis_if.source aa
);

    switch_cfg_pkg::source_id_t head_id;
    logic                       to_up;
    logic                       to_aa;
    logic                       drop;
    logic [3:0]                 discard_cnt;

    assign head_id = switch_cfg_pkg::source_id_t'(head.payload.tid);
    assign to_up   = (head_id == switch_cfg_pkg::SRC_USER_PROJECT);
    assign to_aa   = (head_id == switch_cfg_pkg::SRC_AXIL_BRIDGE);

    assign up.tvalid  = head.tvalid && to_up;
    assign up.payload = head.payload.beat;
    assign aa.tvalid  = head.tvalid && to_aa;
    assign aa.payload = head.payload.beat;

    // ids with no agent are popped straight away
    assign head.tready = to_up ? up.tready : (to_aa ? aa.tready : 1'b1);
    assign drop        = head.tvalid && !to_up && !to_aa;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            discard_cnt <= '0;
        end else if (drop) begin
            discard_cnt <= discard_cnt + 1'b1;
        end
    end

    a_discard_id: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        discard_cnt != $past(discard_cnt) |-> $past(head.payload.tid) inside {2'd2, 2'd3});

    // FIFO must hold its head until this side takes it
    a_head_held: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        head.tvalid && !head.tready |=> head.tvalid);

endmodule

// File: rtl/axis_switch.sv
`timescale 1ns/1ps
`include "axis_switch_macros.svh"

module axis_switch (
    input  logic                         axis_clk,
    input  logic                         axi_reset_n,
    // axi-lite config port
    input  logic                         axi_awvalid,
    input  logic [`AXIL_ADDR_WIDTH-1:0]  axi_awaddr,
    output logic                         axi_awready,
    input  logic                         axi_wvalid,
    input  logic [`AXIS_DATA_WIDTH-1:0]  axi_wdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]  axi_wstrb,
    output logic                         axi_wready,
    input  logic                         axi_arvalid,
    input  logic [`AXIL_ADDR_WIDTH-1:0]  axi_araddr,
    output logic                         axi_arready,
    output logic                         axi_rvalid,
    output logic [`AXIS_DATA_WIDTH-1:0]  axi_rdata,
    input  logic                         axi_rready,
    input  logic                         cc_as_enable,
    // user project source
    input  logic [`AXIS_DATA_WIDTH-1:0]  up_as_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]  up_as_tkeep,
    input  logic                         up_as_tlast,
    input  logic                         up_as_tvalid,
    input  logic [`AXIS_USER_WIDTH-1:0]  up_as_tuser,
    output logic                         as_up_tready,
    // axi-lite bridge source
    input  logic [`AXIS_DATA_WIDTH-1:0]  aa_as_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]  aa_as_tkeep,
    input  logic                         aa_as_tlast,
    input  logic                         aa_as_tvalid,
    input  logic [`AXIS_USER_WIDTH-1:0]  aa_as_tuser,
    output logic                         as_aa_tready,
    // logic analyzer source
    input  logic [`AXIS_DATA_WIDTH-1:0]  la_as_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]  la_as_tkeep,
    input  logic                         la_as_tlast,
    input  logic                         la_as_tvalid,
    input  logic [`AXIS_USER_WIDTH-1:0]  la_as_tuser,
    output logic                         as_la_tready,
    // to io serdes
    output logic [`AXIS_DATA_WIDTH-1:0]  as_is_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0]  as_is_tkeep,
    output logic                         as_is_tlast,
    output logic [`AXIS_TID_WIDTH-1:0]   as_is_tid,
    output logic                         as_is_tvalid,
    output logic [`AXIS_USER_WIDTH-1:0]  as_is_tuser,
    input  logic                         is_as_tready,
    // from io serdes
    input  logic [`AXIS_DATA_WIDTH-1:0]  is_as_tdata,
    input  logic [`AXIS_KEEP_WIDTH-1:0]  is_as_tkeep,
    input  logic                         is_as_tlast,
    input  logic [`AXIS_TID_WIDTH-1:0]   is_as_tid,
    input  logic                         is_as_tvalid,
    input  logic [`AXIS_USER_WIDTH-1:0]  is_as_tuser,
    output logic                         as_is_tready,
    // to user project
    output logic [`AXIS_DATA_WIDTH-1:0]  as_up_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0]  as_up_tkeep,
    output logic                         as_up_tlast,
    output logic                         as_up_tvalid,
    output logic [`AXIS_USER_WIDTH-1:0]  as_up_tuser,
    input  logic                         up_as_tready,
    // to axi-lite bridge
    output logic [`AXIS_DATA_WIDTH-1:0]  as_aa_tdata,
    output logic [`AXIS_KEEP_WIDTH-1:0]  as_aa_tkeep,
    output logic                         as_aa_tlast,
    output logic                         as_aa_tvalid,
    output logic [`AXIS_USER_WIDTH-1:0]  as_aa_tuser,
    input  logic                         aa_as_tready
);

    localparam int N = `AXIS_NUM_SOURCES;

    switch_cfg_pkg::threshold_t threshold;
    axis_beat_pkg::up_beat_t    src_beat [N];
    logic [N-1:0]               src_valid;
    logic [N-1:0]               src_ready;

    axis_if #(.payload_t(axis_beat_pkg::up_beat_t)) src_if [N] ();
    axis_if #(.payload_t(axis_beat_pkg::ds_beat_t)) tx_if ();
    axis_if #(.payload_t(axis_beat_pkg::ds_beat_t)) rx_if ();
    axis_if #(.payload_t(axis_beat_pkg::ds_beat_t)) head_if ();
    axis_if #(.payload_t(axis_beat_pkg::up_beat_t)) up_if ();
    axis_if #(.payload_t(axis_beat_pkg::up_beat_t)) aa_if ();

    ////////////////////////////////////////////////////////////////////////////
    // config register
    ////////////////////////////////////////////////////////////////////////////

    threshold_regs u_regs (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .cc_as_enable (cc_as_enable),
        .awvalid      (axi_awvalid),
        .awaddr       (axi_awaddr),
        .wvalid       (axi_wvalid),
        .wdata        (axi_wdata),
        .wstrb        (axi_wstrb),
        .awready      (axi_awready),
        .wready       (axi_wready),
        .threshold    (threshold)
    );

    // reads always return the threshold, address ignored
    assign axi_arready = 1'b1;
    assign axi_rvalid  = 1'b1;
    assign axi_rdata   = {{(`AXIS_DATA_WIDTH - $bits(threshold)){1'b0}}, threshold};

    ////////////////////////////////////////////////////////////////////////////
    // upstream, sources to serdes
    ////////////////////////////////////////////////////////////////////////////

    // index is the source id
    assign src_beat[0] = '{data: up_as_tdata, keep: up_as_tkeep, last: up_as_tlast,
                           user: up_as_tuser};
    assign src_beat[1] = '{data: aa_as_tdata, keep: aa_as_tkeep, last: aa_as_tlast,
                           user: aa_as_tuser};
    assign src_beat[2] = '{data: la_as_tdata, keep: la_as_tkeep, last: la_as_tlast,
                           user: la_as_tuser};
    assign src_valid   = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};
    assign {as_la_tready, as_aa_tready, as_up_tready} = src_ready;

    for (genvar g = 0; g < N; g++) begin : g_src
        assign src_if[g].tvalid  = src_valid[g];
        assign src_if[g].payload = src_beat[g];
        assign src_ready[g]      = src_if[g].tready;
    end

    frame_arbiter u_arb (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .src         (src_if),
        .out         (tx_if)
    );

    assign as_is_tvalid = tx_if.tvalid;
    assign as_is_tid    = tx_if.payload.tid;
    assign as_is_tdata  = tx_if.payload.beat.data;
    assign as_is_tkeep  = tx_if.payload.beat.keep;
    assign as_is_tlast  = tx_if.payload.beat.last;
    assign as_is_tuser  = tx_if.payload.beat.user;
    assign tx_if.tready = is_as_tready;

    ////////////////////////////////////////////////////////////////////////////
    // downstream, serdes to agents
    ////////////////////////////////////////////////////////////////////////////

    assign rx_if.tvalid       = is_as_tvalid;
    assign rx_if.payload.tid  = is_as_tid;
    assign rx_if.payload.beat = '{data: is_as_tdata, keep: is_as_tkeep, last: is_as_tlast,
                                  user: is_as_tuser};
    assign as_is_tready       = rx_if.tready;

    rx_fifo u_fifo (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .threshold   (threshold),
        .wr          (rx_if),
        .rd          (head_if)
    );

    tid_router u_router (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .head        (head_if),
        .up          (up_if),
        .aa          (aa_if)
    );

    assign as_up_tvalid = up_if.tvalid;
    assign as_up_tdata  = up_if.payload.data;
    assign as_up_tkeep  = up_if.payload.keep;
    assign as_up_tlast  = up_if.payload.last;
    assign as_up_tuser  = up_if.payload.user;
    assign up_if.tready = up_as_tready;

    assign as_aa_tvalid = aa_if.tvalid;
    assign as_aa_tdata  = aa_if.payload.data;
    assign as_aa_tkeep  = aa_if.payload.keep;
    assign as_aa_tlast  = aa_if.payload.last;
    assign as_aa_tuser  = aa_if.payload.user;
    assign aa_if.tready = aa_as_tready;

endmodule

// File: bench/tb_axis_switch.sv
`timescale 1ns/1ps
`include "axis_switch_macros.svh"

module tb_axis_switch;

    logic        axis_clk;
    logic        axi_reset_n;
    logic        axi_awvalid, axi_wvalid, axi_arvalid, axi_rready, cc_as_enable;
    logic [14:0] axi_awaddr, axi_araddr;
    logic [31:0] axi_wdata, axi_rdata;
    logic [3:0]  axi_wstrb;
    logic        axi_awready, axi_wready, axi_arready, axi_rvalid;
    logic [31:0] src_data [3];
    logic        src_valid [3];
    logic        src_last [3];
    logic [2:0]  src_rdy;
    logic [31:0] as_is_tdata, is_as_tdata, as_up_tdata, as_aa_tdata;
    logic [3:0]  as_is_tkeep, as_up_tkeep, as_aa_tkeep;
    logic [1:0]  as_is_tuser, as_up_tuser, as_aa_tuser, as_is_tid, is_as_tid;
    logic        as_is_tlast, as_is_tvalid, is_as_tready, is_as_tvalid, as_is_tready;
    logic        as_up_tlast, as_up_tvalid, up_as_tready;
    logic        as_aa_tlast, as_aa_tvalid, aa_as_tready;

    // 0 always ready, 1 random, 2 held low
    int          serdes_mode;
    int          agent_mode;
    int          cycles;
    int          sent_cnt [3];
    int          rx_seq [4];
    bit          exp_last [3][64];
    int          rr_next;
    int          cur_tid;
    bit          in_frame;
    int          down_seq;
    logic [31:0] q_up [$];
    logic [31:0] q_aa [$];

    // keep and user ride on low sequence bits, downstream tlast on bit 6
    axis_switch dut0 (
        .axis_clk(axis_clk), .axi_reset_n(axi_reset_n),
        .axi_awvalid(axi_awvalid), .axi_awaddr(axi_awaddr), .axi_awready(axi_awready),
        .axi_wvalid(axi_wvalid), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
        .axi_wready(axi_wready), .axi_arvalid(axi_arvalid), .axi_araddr(axi_araddr),
        .axi_arready(axi_arready), .axi_rvalid(axi_rvalid), .axi_rdata(axi_rdata),
        .axi_rready(axi_rready), .cc_as_enable(cc_as_enable),
        .up_as_tdata(src_data[0]), .up_as_tkeep(src_data[0][3:0]),
        .up_as_tlast(src_last[0]), .up_as_tvalid(src_valid[0]),
        .up_as_tuser(src_data[0][5:4]), .as_up_tready(src_rdy[0]),
        .aa_as_tdata(src_data[1]), .aa_as_tkeep(src_data[1][3:0]),
        .aa_as_tlast(src_last[1]), .aa_as_tvalid(src_valid[1]),
        .aa_as_tuser(src_data[1][5:4]), .as_aa_tready(src_rdy[1]),
        .la_as_tdata(src_data[2]), .la_as_tkeep(src_data[2][3:0]),
        .la_as_tlast(src_last[2]), .la_as_tvalid(src_valid[2]),
        .la_as_tuser(src_data[2][5:4]), .as_la_tready(src_rdy[2]),
        .as_is_tdata(as_is_tdata), .as_is_tkeep(as_is_tkeep), .as_is_tlast(as_is_tlast),
        .as_is_tid(as_is_tid), .as_is_tvalid(as_is_tvalid), .as_is_tuser(as_is_tuser),
        .is_as_tready(is_as_tready),
        .is_as_tdata(is_as_tdata), .is_as_tkeep(is_as_tdata[3:0]),
        .is_as_tlast(is_as_tdata[6]), .is_as_tid(is_as_tid), .is_as_tvalid(is_as_tvalid),
        .is_as_tuser(is_as_tdata[5:4]), .as_is_tready(as_is_tready),
        .as_up_tdata(as_up_tdata), .as_up_tkeep(as_up_tkeep), .as_up_tlast(as_up_tlast),
        .as_up_tvalid(as_up_tvalid), .as_up_tuser(as_up_tuser), .up_as_tready(up_as_tready),
        .as_aa_tdata(as_aa_tdata), .as_aa_tkeep(as_aa_tkeep), .as_aa_tlast(as_aa_tlast),
        .as_aa_tvalid(as_aa_tvalid), .as_aa_tuser(as_aa_tuser), .aa_as_tready(aa_as_tready)
    );

    task automatic report_mismatch(input string name, input longint got, input longint exp);
        $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("TB FAILED");
        $fatal(1, "value check failed");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    // agent beat against the serdes beat that was sent
    task automatic check_agent_beat(input string port, input logic [31:0] data,
                                    input logic [3:0] keep, input logic last,
                                    input logic [1:0] user, input logic [31:0] exp);
        assert (data == exp) else report_mismatch({port, "_tdata"}, data, exp);
        assert (keep == exp[3:0]) else report_mismatch({port, "_tkeep"}, keep, exp[3:0]);
        assert (last == exp[6]) else report_mismatch({port, "_tlast"}, last, exp[6]);
        assert (user == exp[5:4]) else report_mismatch({port, "_tuser"}, user, exp[5:4]);
    endtask

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            report_error("timeout, run did not finish within 4000 cycles");
        end
    end

    // ready drivers for the serdes and both agents
    always @(posedge axis_clk) begin
        #1;
        is_as_tready = (serdes_mode == 1) ? 1'($urandom % 2) : 1'b1;
        up_as_tready = (agent_mode == 1) ? 1'($urandom % 2) : (agent_mode == 0);
        aa_as_tready = (agent_mode == 1) ? 1'($urandom % 2) : (agent_mode == 0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // monitors, sampled at negedge where all inputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge axis_clk) begin
        int seq;
        if (axi_reset_n && as_is_tvalid && is_as_tready) begin
            assert (as_is_tid == as_is_tdata[31:24])
                else report_mismatch("as_is_tid", as_is_tid, as_is_tdata[31:24]);
            if (!in_frame) begin
                assert (as_is_tid == rr_next)
                    else report_mismatch("as_is_tid frame order", as_is_tid, rr_next);
                cur_tid  = as_is_tid;
                in_frame = 1'b1;
            end
            assert (as_is_tid == cur_tid)
                else report_mismatch("as_is_tid interleave", as_is_tid, cur_tid);
            seq = rx_seq[as_is_tid];
            assert (as_is_tdata[23:0] == seq)
                else report_mismatch("as_is_tdata", as_is_tdata[23:0], seq);
            assert (as_is_tlast == exp_last[as_is_tid][seq])
                else report_mismatch("as_is_tlast", as_is_tlast, exp_last[as_is_tid][seq]);
            assert (as_is_tkeep == 4'(seq))
                else report_mismatch("as_is_tkeep", as_is_tkeep, 4'(seq));
            assert (as_is_tuser == 2'(seq >> 4))
                else report_mismatch("as_is_tuser", as_is_tuser, 2'(seq >> 4));
            rx_seq[as_is_tid] = seq + 1;
            if (as_is_tlast) begin
                in_frame = 1'b0;
                rr_next  = (as_is_tid + 1) % 3;
            end
        end
        if (axi_reset_n && as_up_tvalid && up_as_tready) begin
            assert (q_up.size() > 0) else report_error("unexpected beat on as_up");
            check_agent_beat("as_up", as_up_tdata, as_up_tkeep, as_up_tlast, as_up_tuser,
                             q_up[0]);
            void'(q_up.pop_front());
        end
        if (axi_reset_n && as_aa_tvalid && aa_as_tready) begin
            assert (q_aa.size() > 0) else report_error("unexpected beat on as_aa");
            check_agent_beat("as_aa", as_aa_tdata, as_aa_tkeep, as_aa_tlast, as_aa_tuser,
                             q_aa[0]);
            void'(q_aa.pop_front());
        end
    end

    a_out_held: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        as_is_tvalid && !is_as_tready |=> as_is_tvalid
            && $stable({as_is_tid, as_is_tdata, as_is_tkeep, as_is_tlast, as_is_tuser}))
        else report_error("as_is beat changed or dropped before it was accepted");

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic axil_write(input logic [14:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic en);
        axi_awvalid  = 1'b1;
        axi_wvalid   = 1'b1;
        axi_awaddr   = addr;
        axi_wdata    = data;
        axi_wstrb    = strb;
        cc_as_enable = en;
        @(negedge axis_clk);
        assert (axi_awready == en) else report_mismatch("axi_awready", axi_awready, en);
        assert (axi_wready == en) else report_mismatch("axi_wready", axi_wready, en);
        @(posedge axis_clk);
        #1;
        axi_awvalid  = 1'b0;
        axi_wvalid   = 1'b0;
        cc_as_enable = 1'b1;
    endtask

    // frames of 1 to 4 beats, valid kept high between beats
    task automatic send_frames(input int s, input int nfr);
        int len;
        bit acc;
        for (int f = 0; f < nfr; f++) begin
            len = 1 + $urandom % 4;
            for (int b = 0; b < len; b++) begin
                src_valid[s] = 1'b1;
                src_data[s]  = {8'(s), 24'(sent_cnt[s])};
                src_last[s]  = (b == len - 1);
                exp_last[s][sent_cnt[s]] = (b == len - 1);
                do begin
                    @(negedge axis_clk);
                    acc = src_rdy[s];
                    @(posedge axis_clk);
                    #1;
                end while (!acc);
                sent_cnt[s]++;
            end
        end
        src_valid[s] = 1'b0;
    endtask

    task automatic send_down(input int n, input bit rand_id);
        logic [1:0] id;
        bit         acc;
        for (int i = 0; i < n; i++) begin
            id           = rand_id ? 2'($urandom % 4) : 2'd0;
            is_as_tvalid = 1'b1;
            is_as_tid    = id;
            is_as_tdata  = 32'(down_seq);
            do begin
                @(negedge axis_clk);
                acc = as_is_tready;
                @(posedge axis_clk);
                #1;
            end while (!acc);
            if (id == 2'd0) q_up.push_back(32'(down_seq));
            if (id == 2'd1) q_aa.push_back(32'(down_seq));
            down_seq++;
        end
        is_as_tvalid = 1'b0;
    endtask

    task automatic wait_upstream_done();
        while (rx_seq[0] != sent_cnt[0] || rx_seq[1] != sent_cnt[1]
               || rx_seq[2] != sent_cnt[2]) begin
            @(posedge axis_clk);
            #1;
        end
    endtask

    initial begin
        int cnt;
        void'($urandom(32'h0c2bd84a));
        cycles = 0;
        serdes_mode = 0;
        agent_mode = 0;
        rr_next = 0;
        in_frame = 0;
        cur_tid = 0;
        down_seq = 0;
        axi_reset_n = 1'b0;
        axi_awvalid = 0;
        axi_wvalid = 0;
        axi_arvalid = 0;
        axi_rready = 1'b1;
        cc_as_enable = 1'b1;
        axi_awaddr = '0;
        axi_araddr = '0;
        axi_wdata = '0;
        axi_wstrb = '0;
        is_as_tready = 1'b1;
        is_as_tvalid = 1'b0;
        is_as_tid = '0;
        is_as_tdata = '0;
        up_as_tready = 1'b1;
        aa_as_tready = 1'b1;
        for (int s = 0; s < 3; s++) begin
            src_valid[s] = 1'b0;
            src_data[s] = '0;
            src_last[s] = 1'b0;
            sent_cnt[s] = 0;
        end
        for (int i = 0; i < 4; i++) rx_seq[i] = 0;
        repeat (8) @(posedge axis_clk);
        #1;
        axi_reset_n = 1'b1;
        @(negedge axis_clk);
        assert (!as_is_tvalid && !as_up_tvalid && !as_aa_tvalid && src_rdy == 3'b000)
            else report_error("outputs active after reset");
        assert (as_is_tready) else report_mismatch("as_is_tready", as_is_tready, 1);
        assert (axi_rdata == 32'd6) else report_mismatch("axi_rdata", axi_rdata, 6);
        assert (axi_arready == 1'b1) else report_mismatch("axi_arready", axi_arready, 1);
        assert (axi_rvalid == 1'b1) else report_mismatch("axi_rvalid", axi_rvalid, 1);
        @(posedge axis_clk);
        #1;

        // threshold register, only offset 0 with strobe 0 and enable counts
        axil_write(15'h0, 32'd9, 4'hf, 1'b0);
        assert (axi_rdata == 32'd6) else report_mismatch("axi_rdata", axi_rdata, 6);
        axil_write(15'h4, 32'd9, 4'hf, 1'b1);
        axil_write(15'h0, 32'd9, 4'he, 1'b1);
        assert (axi_rdata == 32'd6) else report_mismatch("axi_rdata", axi_rdata, 6);
        axil_write(15'h0, 32'd9, 4'h1, 1'b1);
        assert (axi_rdata == 32'd9) else report_mismatch("axi_rdata", axi_rdata, 9);

        // upstream, free flowing then with serdes back-pressure
        for (int phase = 0; phase < 2; phase++) begin
            serdes_mode = phase;
            fork
                send_frames(0, 8);
                send_frames(1, 8);
                send_frames(2, 8);
            join
            wait_upstream_done();
        end
        serdes_mode = 0;

        // downstream routing with random agent readys
        agent_mode = 1;
        send_down(200, 1'b1);
        while (q_up.size() != 0 || q_aa.size() != 0) @(posedge axis_clk);
        agent_mode = 2;
        // let any trailing id 2 and 3 beats drop out of the FIFO
        repeat (`AXIS_FIFO_DEPTH) @(posedge axis_clk);
        #1;

        // threshold back-pressure with both agents stalled
        axil_write(15'h0, 32'd3, 4'h1, 1'b1);
        cnt = 0;
        is_as_tvalid = 1'b1;
        is_as_tid    = 2'd0;
        forever begin
            is_as_tdata = 32'(down_seq);
            @(negedge axis_clk);
            if (!as_is_tready) break;
            q_up.push_back(32'(down_seq));
            down_seq++;
            cnt++;
            @(posedge axis_clk);
            #1;
        end
        @(posedge axis_clk);
        #1;
        is_as_tvalid = 1'b0;
        assert (cnt == 4) else report_mismatch("accepted beats at threshold 3", cnt, 4);
        agent_mode = 0;
        while (!as_is_tready || q_up.size() != 0) @(posedge axis_clk);
        repeat (4) @(posedge axis_clk);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/axis_beat_pkg.sv
rtl/switch_cfg_pkg.sv
rtl/axis_if.sv
rtl/threshold_regs.sv
rtl/frame_arbiter.sv
rtl/rx_fifo.sv
rtl/tid_router.sv
rtl/axis_switch.sv
bench/tb_axis_switch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the axis_switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_axis_switch \
    -f vlog.f \
    -o sim_axis_switch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_axis_switch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished"
exit 0
